// File: basic_map.mem
// Tile codes 0 floor, 1 wall, 2 brick, 3 bomb
// One map row per line, 19 columns each, row 0 at the top
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
1 0 0 2 0 0 2 0 2 0 0 2 2 0 2 0 0 0 1
1 0 1 2 1 0 1 2 1 0 1 2 1 0 1 2 1 0 1
1 2 0 0 2 0 2 0 0 2 0 0 2 0 0 2 0 2 1
1 0 1 0 1 2 1 0 1 2 1 0 1 2 1 0 1 0 1
1 2 2 0 0 0 2 2 0 0 0 2 0 0 2 2 0 0 1
1 0 1 2 1 0 1 0 1 2 1 0 1 2 1 0 1 2 1
1 0 2 0 0 2 0 0 2 0 2 0 0 2 0 0 2 0 1
1 2 1 0 1 0 1 2 1 0 1 2 1 0 1 2 1 0 1
1 0 0 2 0 2 0 0 0 2 0 0 2 0 2 0 0 0 1
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1

// File: build.f
+incdir+include
rtl/bomber_pkg.sv
rtl/map_mem.sv
rtl/player_controller.sv
rtl/bomb_req_fifo.sv
rtl/bomb_logic.sv
rtl/game_core_top.sv
verif/tb_game_core.sv

// File: Makefile
VERILATOR  ?= verilator
TB_TOP     ?= tb_game_core
RTL_TOP    ?= game_core_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_game_core.sv
`timescale 1ns/1ps

module tb_game_core import bomber_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RST_CYCLES   = 16;
  localparam int SEED         = 73;
  localparam int NUM_TICKS    = 400;
  localparam int TICK_CYCLES  = 32;
  localparam int PRESS_CYCLE  = 4;   // Button pulse, cycles after the tick
  localparam int CHECK_CYCLE  = 28;
  localparam int SWEEP_CYCLES = MAP_DEPTH;
  localparam int WDOG_CYCLES  = RST_CYCLES + SWEEP_CYCLES +
                                NUM_TICKS * (TICK_CYCLES + SWEEP_CYCLES) + 1000;

  logic                      pixclk;
  logic                      rst;
  logic                      tick;
  logic                      up;
  logic                      down;
  logic                      left;
  logic                      right;
  logic                      place_bomb;
  logic [MAP_ADDR_WIDTH-1:0] view_addr;
  tile_t                     view_tile;
  logic [POS_X_WIDTH-1:0]    player_x;
  logic [POS_Y_WIDTH-1:0]    player_y;
  logic                      bomb_armed;

  // Reference model state
  logic [1:0] model_map [MAP_DEPTH];
  int         model_x;
  int         model_y;
  logic       model_armed;
  int         model_fuse;
  bomb_req_t  live_bomb;     // Tile of the armed bomb
  bomb_req_t  pending_q[$];  // Mirrors the request queue
  int         err_cnt;
  int         check_cnt;

  game_core_top dut_i (
    .i_pixclk    (pixclk),
    .i_rst       (rst),
    .i_tick      (tick),
    .i_up        (up),
    .i_down      (down),
    .i_left      (left),
    .i_right     (right),
    .i_place_bomb(place_bomb),
    .i_view_addr (view_addr),
    .o_view_tile (view_tile),
    .o_player_x  (player_x),
    .o_player_y  (player_y),
    .o_bomb_armed(bomb_armed)
  );

  initial begin
    pixclk = 1'b0;
    forever #(CLK_PERIOD / 2) pixclk = ~pixclk;
  end

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", WDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_cnt++;
    if (expected !== actual) begin
      err_cnt++;
      $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
    end
  endtask

  function automatic int tile_index(input int row, input int col);
    return row * MAP_NUM_COL + col;  // Row major, 19 tiles per row
  endfunction

  task automatic model_move(input logic [3:0] dirs);
    int   tx;
    int   ty;
    logic same;
    tx = model_x;
    ty = model_y;
    case (dirs)  // {up, down, left, right}
      4'b1000: ty = model_y - STEP_SIZE;
      4'b0100: ty = model_y + STEP_SIZE;
      4'b0010: tx = model_x - STEP_SIZE;
      4'b0001: tx = model_x + STEP_SIZE;
      default: ;  // Zero or several held, stay put
    endcase
    same = ((tx >> TILE_SHIFT) == (model_x >> TILE_SHIFT)) &&
           ((ty >> TILE_SHIFT) == (model_y >> TILE_SHIFT));
    if (same || model_map[tile_index(ty >> TILE_SHIFT, tx >> TILE_SHIFT)] == FLOOR) begin
      model_x = tx;
      model_y = ty;
    end
  endtask

  task automatic model_arm(input bomb_req_t req);
    live_bomb   = req;
    model_map[tile_index(int'(req.row), int'(req.col))] = BOMB;
    model_armed = 1'b1;
    model_fuse  = FUSE_TICKS;
  endtask

  task automatic model_explode();
    int dr[4];
    int dc[4];
    int row;
    int col;
    int k;
    dr = '{-1, 1, 0, 0};  // Up, down, left, right
    dc = '{0, 0, -1, 1};
    for (k = 0; k < 4; k++) begin
      row = int'(live_bomb.row) + dr[k];
      col = int'(live_bomb.col) + dc[k];
      if (row >= 0 && row < MAP_NUM_ROW && col >= 0 && col < MAP_NUM_COL) begin
        if (model_map[tile_index(row, col)] == BRICK) begin
          model_map[tile_index(row, col)] = FLOOR;  // Walls stay
        end
      end
    end
    model_map[tile_index(int'(live_bomb.row), int'(live_bomb.col))] = FLOOR;
    model_armed = 1'b0;
  endtask

  // One frame in the order the core resolves it
  task automatic model_frame(input logic [3:0] dirs, input logic press);
    logic      boom;
    bomb_req_t here;
    model_move(dirs);
    boom = 1'b0;
    if (model_armed) begin
      model_fuse--;
      boom = (model_fuse == 0);
    end
    if (press) begin
      here.row = 4'(model_y >> TILE_SHIFT);
      here.col = 5'(model_x >> TILE_SHIFT);
      if (!model_armed) model_arm(here);
      else if (pending_q.size() < BOMB_QUEUE_DEPTH) pending_q.push_back(here);
    end
    // Explosion ends before the queue is popped
    if (boom) begin
      model_explode();
      if (pending_q.size() != 0) model_arm(pending_q.pop_front());
    end
  endtask

  task automatic check_state();
    compare_value("o_player_x", 32'(model_x), 32'(player_x));
    compare_value("o_player_y", 32'(model_y), 32'(player_y));
    compare_value("o_bomb_armed", 32'(model_armed), 32'(bomb_armed));
  endtask

  // View port read has one cycle of latency
  task automatic sweep_map();
    int a;
    view_addr = '0;
    for (a = 0; a < MAP_DEPTH; a++) begin
      @(negedge pixclk);
      compare_value($sformatf("o_view_tile[%0d]", a), 32'(model_map[a]), 32'(view_tile));
      view_addr = MAP_ADDR_WIDTH'((a + 1) % MAP_DEPTH);
    end
  endtask

  task automatic run_frame();
    logic [3:0] dirs;
    logic       press;
    int         pick;
    pick = int'($urandom % 8);
    if (pick < 6) begin
      dirs = 4'b0001 << ($urandom % 4);  // Mostly a single direction
    end else if (pick == 6) begin
      dirs = 4'b0000;
    end else begin
      do begin
        dirs = 4'($urandom);
      end while ($countones(dirs) != 2);
    end
    press = (($urandom % 6) == 0);
    @(negedge pixclk);
    {up, down, left, right} = dirs;
    tick = 1'b1;
    @(negedge pixclk);
    tick = 1'b0;
    repeat (PRESS_CYCLE - 1) @(negedge pixclk);
    place_bomb = press;
    @(negedge pixclk);
    place_bomb = 1'b0;
    repeat (CHECK_CYCLE - PRESS_CYCLE - 1) @(negedge pixclk);
    model_frame(dirs, press);
    check_state();
    sweep_map();  // Core is quiet until the next tick
    repeat (TICK_CYCLES - CHECK_CYCLE - 1) @(negedge pixclk);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(SEED));
    err_cnt     = 0;
    check_cnt   = 0;
    rst         = 1'b1;
    tick        = 1'b0;
    up          = 1'b0;
    down        = 1'b0;
    left        = 1'b0;
    right       = 1'b0;
    place_bomb  = 1'b0;
    view_addr   = '0;
    $readmemh("basic_map.mem", model_map);
    model_x     = INIT_X;
    model_y     = INIT_Y;
    model_armed = 1'b0;
    model_fuse  = 0;
    repeat (RST_CYCLES) @(negedge pixclk);
    rst = 1'b0;
    check_state();
    sweep_map();
    repeat (NUM_TICKS) run_frame();
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: rtl/game_core_top.sv
`timescale 1ns/1ps

module game_core_top import bomber_pkg::*; (
  input  logic                      i_pixclk,
  input  logic                      i_rst,
  input  logic                      i_tick,
  input  logic                      i_up,
  input  logic                      i_down,
  input  logic                      i_left,
  input  logic                      i_right,
  input  logic                      i_place_bomb,
  input  logic [MAP_ADDR_WIDTH-1:0] i_view_addr,
  output tile_t                     o_view_tile,
  output logic [POS_X_WIDTH-1:0]    o_player_x,
  output logic [POS_Y_WIDTH-1:0]    o_player_y,
  output logic                      o_bomb_armed
);

  logic [1:0]                rd_req;
  logic [1:0]                rd_grant;
  logic [MAP_ADDR_WIDTH-1:0] pc_rd_addr;
  logic [MAP_ADDR_WIDTH-1:0] bl_rd_addr;
  tile_t                     rd_tile;
  bomb_req_t                 push_req;
  logic                      push_valid;
  logic                      push_ready;
  bomb_req_t                 pop_req;
  logic                      pop_valid;
  logic                      pop_ready;
  logic                      wr_en;
  logic [MAP_ADDR_WIDTH-1:0] wr_addr;
  tile_t                     wr_tile;

  player_controller player_ctrl_i (
    .i_pixclk    (i_pixclk),
    .i_rst       (i_rst),
    .i_tick      (i_tick),
    .i_up        (i_up),
    .i_down      (i_down),
    .i_left      (i_left),
    .i_right     (i_right),
    .i_place_bomb(i_place_bomb),
    .o_rd_req    (rd_req[0]),
    .o_rd_addr   (pc_rd_addr),
    .i_rd_grant  (rd_grant[0]),
    .i_rd_tile   (rd_tile),
    .o_bomb_req  (push_req),
    .o_bomb_valid(push_valid),
    .i_bomb_ready(push_ready),
    .o_player_x  (o_player_x),
    .o_player_y  (o_player_y)
  );

  bomb_req_fifo #(.DEPTH(BOMB_QUEUE_DEPTH)) bomb_fifo_i (
    .i_pixclk(i_pixclk),
    .i_rst   (i_rst),
    .i_req   (push_req),
    .i_valid (push_valid),
    .o_ready (push_ready),
    .o_req   (pop_req),
    .o_valid (pop_valid),
    .i_ready (pop_ready)
  );

  bomb_logic bomb_logic_i (
    .i_pixclk    (i_pixclk),
    .i_rst       (i_rst),
    .i_tick      (i_tick),
    .i_req       (pop_req),
    .i_valid     (pop_valid),
    .o_ready     (pop_ready),
    .o_rd_req    (rd_req[1]),
    .o_rd_addr   (bl_rd_addr),
    .i_rd_grant  (rd_grant[1]),
    .i_rd_tile   (rd_tile),
    .o_wr_en     (wr_en),
    .o_wr_addr   (wr_addr),
    .o_wr_tile   (wr_tile),
    .o_bomb_armed(o_bomb_armed)
  );

  map_mem map_mem_i (
    .i_pixclk   (i_pixclk),
    .i_rd_req   (rd_req),
    .i_rd_addr_0(pc_rd_addr),
    .i_rd_addr_1(bl_rd_addr),
    .o_rd_grant (rd_grant),
    .o_rd_tile  (rd_tile),
    .i_view_addr(i_view_addr),
    .o_view_tile(o_view_tile),
    .i_wr_en    (wr_en),
    .i_wr_addr  (wr_addr),
    .i_wr_tile  (wr_tile)
  );

endmodule

// File: rtl/bomb_logic.sv
`timescale 1ns/1ps

module bomb_logic import bomber_pkg::*; (
  input  logic                      i_pixclk,
  input  logic                      i_rst,
  input  logic                      i_tick,
  input  bomb_req_t                 i_req,
  input  logic                      i_valid,
  output logic                      o_ready,
  output logic                      o_rd_req,
  output logic [MAP_ADDR_WIDTH-1:0] o_rd_addr,
  input  logic                      i_rd_grant,
  input  tile_t                     i_rd_tile,
  output logic                      o_wr_en,
  output logic [MAP_ADDR_WIDTH-1:0] o_wr_addr,
  output tile_t                     o_wr_tile,
  output logic                      o_bomb_armed
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ARMED,
    S_NB_REQ,   // Read a neighbour
    S_NB_WAIT,  // Neighbour tile on i_rd_tile
    S_CENTER
  } state_t;

  state_t                state;
  bomb_req_t             bomb_pos;
  logic [FUSE_WIDTH-1:0] fuse_cnt;
  logic [1:0]            nb_idx;  // Up, down, left, right
  logic [3:0]            nb_row;
  logic [4:0]            nb_col;
  logic                  nb_ok;

  always_comb begin
    nb_row = bomb_pos.row;
    nb_col = bomb_pos.col;
    case (nb_idx)
      2'd0: begin
        nb_row = bomb_pos.row - 4'd1;
        nb_ok  = (bomb_pos.row != '0);
      end
      2'd1: begin
        nb_row = bomb_pos.row + 4'd1;
        nb_ok  = (bomb_pos.row < 4'(MAP_NUM_ROW - 1));
      end
      2'd2: begin
        nb_col = bomb_pos.col - 5'd1;
        nb_ok  = (bomb_pos.col != '0);
      end
      default: begin
        nb_col = bomb_pos.col + 5'd1;
        nb_ok  = (bomb_pos.col < 5'(MAP_NUM_COL - 1));
      end
    endcase
  end

  assign o_ready      = (state == S_IDLE);
  assign o_bomb_armed = (state != S_IDLE);
  assign o_rd_req     = (state == S_NB_REQ) && nb_ok;
  assign o_rd_addr    = tile_addr(nb_row, nb_col);

  always_ff @(posedge i_pixclk) begin
    if (i_rst) begin
      state    <= S_IDLE;
      fuse_cnt <= '0;
      nb_idx   <= '0;
      o_wr_en  <= 1'b0;
    end else begin
      o_wr_en <= 1'b0;
      case (state)
        S_IDLE: if (i_valid) begin
          fuse_cnt <= FUSE_WIDTH'(FUSE_TICKS);
          o_wr_en  <= 1'b1;  // Drop the bomb
          state    <= S_ARMED;
        end
        S_ARMED: if (i_tick) begin
          fuse_cnt <= fuse_cnt - 1'b1;
          if (fuse_cnt == FUSE_WIDTH'(1)) begin
            nb_idx <= '0;
            state  <= S_NB_REQ;
          end
        end
        S_NB_REQ: begin
          if (!nb_ok) begin  // Off the map edge, skip
            nb_idx <= nb_idx + 1'b1;
            state  <= (nb_idx == 2'd3) ? S_CENTER : S_NB_REQ;
          end else if (i_rd_grant) begin
            state <= S_NB_WAIT;
          end
        end
        S_NB_WAIT: begin
          o_wr_en <= (i_rd_tile == BRICK);  // Walls survive
          nb_idx  <= nb_idx + 1'b1;
          state   <= (nb_idx == 2'd3) ? S_CENTER : S_NB_REQ;
        end
        S_CENTER: begin
          o_wr_en <= 1'b1;
          state   <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_pixclk) begin
    case (state)
      S_IDLE: if (i_valid) begin
        bomb_pos  <= i_req;
        o_wr_addr <= tile_addr(i_req.row, i_req.col);
        o_wr_tile <= BOMB;
      end
      S_NB_WAIT: begin
        o_wr_addr <= o_rd_addr;
        o_wr_tile <= FLOOR;
      end
      S_CENTER: begin
        o_wr_addr <= tile_addr(bomb_pos.row, bomb_pos.col);
        o_wr_tile <= FLOOR;
      end
      default: ;
    endcase
  end

  a_wr_in_map: assert property (@(posedge i_pixclk) disable iff (i_rst)
    o_wr_en |-> o_wr_addr < MAP_ADDR_WIDTH'(MAP_DEPTH));

endmodule

// File: rtl/bomb_req_fifo.sv
`timescale 1ns/1ps

module bomb_req_fifo import bomber_pkg::*; #(
  parameter int DEPTH = BOMB_QUEUE_DEPTH
) (
  input  logic      i_pixclk,
  input  logic      i_rst,
  input  bomb_req_t i_req,
  input  logic      i_valid,
  output logic      o_ready,
  output bomb_req_t o_req,
  output logic      o_valid,
  input  logic      i_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  bomb_req_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(DEPTH));
  assign o_valid = (count != '0);
  assign o_ready = ~full | i_ready;  // Pop frees a slot on the same edge
  assign push    = i_valid & o_ready;
  assign pop     = o_valid & i_ready;
  assign o_req   = mem[rd_ptr];

  always_ff @(posedge i_pixclk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_pixclk) begin
    if (push) mem[wr_ptr] <= i_req;
  end

  a_count_range: assert property (@(posedge i_pixclk) disable iff (i_rst)
    count <= CNT_W'(DEPTH));
  a_out_hold: assert property (@(posedge i_pixclk) disable iff (i_rst)
    o_valid && !i_ready |=> o_valid && $stable(o_req));

endmodule

// File: rtl/player_controller.sv
`timescale 1ns/1ps

module player_controller import bomber_pkg::*; (
  input  logic                      i_pixclk,
  input  logic                      i_rst,
  input  logic                      i_tick,
  input  logic                      i_up,
  input  logic                      i_down,
  input  logic                      i_left,
  input  logic                      i_right,
  input  logic                      i_place_bomb,
  output logic                      o_rd_req,
  output logic [MAP_ADDR_WIDTH-1:0] o_rd_addr,
  input  logic                      i_rd_grant,
  input  tile_t                     i_rd_tile,
  output bomb_req_t                 o_bomb_req,
  output logic                      o_bomb_valid,
  input  logic                      i_bomb_ready,
  output logic [POS_X_WIDTH-1:0]    o_player_x,
  output logic [POS_Y_WIDTH-1:0]    o_player_y
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,   // Waiting for the shared read port
    S_CHECK   // Target tile on i_rd_tile
  } state_t;

  state_t                 state;
  dir_t                   move_dir;
  logic [POS_X_WIDTH-1:0] tgt_x;
  logic [POS_Y_WIDTH-1:0] tgt_y;
  logic [3:0]             cur_row;
  logic [3:0]             tgt_row;
  logic [4:0]             cur_col;
  logic [4:0]             tgt_col;
  logic                   same_tile;
  logic                   place_q;

  always_comb begin
    case ({i_up, i_down, i_left, i_right})
      4'b1000: move_dir = DIR_UP;
      4'b0100: move_dir = DIR_DOWN;
      4'b0010: move_dir = DIR_LEFT;
      4'b0001: move_dir = DIR_RIGHT;
      default: move_dir = DIR_NONE;  // None or several held
    endcase
  end

  assign cur_row   = o_player_y[POS_Y_WIDTH-1:TILE_SHIFT];
  assign cur_col   = o_player_x[POS_X_WIDTH-1:TILE_SHIFT];
  assign tgt_row   = tgt_y[POS_Y_WIDTH-1:TILE_SHIFT];
  assign tgt_col   = tgt_x[POS_X_WIDTH-1:TILE_SHIFT];
  assign same_tile = (tgt_row == cur_row) && (tgt_col == cur_col);

  assign o_rd_req  = (state == S_READ);
  assign o_rd_addr = tile_addr(tgt_row, tgt_col);

  always_ff @(posedge i_pixclk) begin
    if (i_rst) begin
      state      <= S_IDLE;
      o_player_x <= POS_X_WIDTH'(INIT_X);
      o_player_y <= POS_Y_WIDTH'(INIT_Y);
    end else begin
      case (state)
        S_IDLE: if (i_tick && move_dir != DIR_NONE) state <= S_READ;
        S_READ: if (i_rd_grant) state <= S_CHECK;
        S_CHECK: begin
          // Free to move inside the own tile, even onto a fresh bomb
          if (same_tile || i_rd_tile == FLOOR) begin
            o_player_x <= tgt_x;
            o_player_y <= tgt_y;
          end
          state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Target point, taken on the tick
  always_ff @(posedge i_pixclk) begin
    if (state == S_IDLE && i_tick) begin
      tgt_x <= o_player_x;
      tgt_y <= o_player_y;
      case (move_dir)
        DIR_UP:    tgt_y <= o_player_y - POS_Y_WIDTH'(STEP_SIZE);
        DIR_DOWN:  tgt_y <= o_player_y + POS_Y_WIDTH'(STEP_SIZE);
        DIR_LEFT:  tgt_x <= o_player_x - POS_X_WIDTH'(STEP_SIZE);
        DIR_RIGHT: tgt_x <= o_player_x + POS_X_WIDTH'(STEP_SIZE);
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_pixclk) begin
    if (i_rst) begin
      place_q      <= 1'b0;
      o_bomb_valid <= 1'b0;
    end else begin
      place_q      <= i_place_bomb;
      o_bomb_valid <= i_place_bomb & ~place_q;  // Rising edge only
    end
  end

  always_ff @(posedge i_pixclk) begin
    o_bomb_req <= '{row: cur_row, col: cur_col};
  end

  // One request per press, taken by the queue or dropped within its cycle
  a_no_reissue: assert property (@(posedge i_pixclk) disable iff (i_rst)
    o_bomb_valid |=> !o_bomb_valid);

endmodule

// File: rtl/map_mem.sv
`timescale 1ns/1ps

module map_mem import bomber_pkg::*; (
  input  logic                      i_pixclk,
  input  logic [1:0]                i_rd_req,
  input  logic [MAP_ADDR_WIDTH-1:0] i_rd_addr_0,
  input  logic [MAP_ADDR_WIDTH-1:0] i_rd_addr_1,
  output logic [1:0]                o_rd_grant,
  output tile_t                     o_rd_tile,
  input  logic [MAP_ADDR_WIDTH-1:0] i_view_addr,
  output tile_t                     o_view_tile,
  input  logic                      i_wr_en,
  input  logic [MAP_ADDR_WIDTH-1:0] i_wr_addr,
  input  tile_t                     i_wr_tile
);

  logic [$bits(tile_t)-1:0]  ram [MAP_DEPTH];
  logic [MAP_ADDR_WIDTH-1:0] rd_addr;

  initial begin
    $readmemh("basic_map.mem", ram);
  end

  // Player first, bomb logic second
  assign o_rd_grant[0] = i_rd_req[0];
  assign o_rd_grant[1] = i_rd_req[1] & ~i_rd_req[0];
  assign rd_addr       = o_rd_grant[0] ? i_rd_addr_0 : i_rd_addr_1;

  always_ff @(posedge i_pixclk) begin
    if (i_wr_en) ram[i_wr_addr] <= i_wr_tile;
    o_rd_tile   <= tile_t'(ram[rd_addr]);  // Old data on a same cycle write
    o_view_tile <= tile_t'(ram[i_view_addr]);
  end

  a_grant_onehot: assert property (@(posedge i_pixclk) $onehot0(o_rd_grant));

endmodule

// File: rtl/bomber_pkg.sv
package bomber_pkg;

  `include "bomber_dir.svh"

  // Map geometry in tiles
  localparam int MAP_NUM_ROW    = 11;
  localparam int MAP_NUM_COL    = 19;
  localparam int MAP_DEPTH      = MAP_NUM_ROW * MAP_NUM_COL;
  localparam int MAP_ADDR_WIDTH = $clog2(MAP_DEPTH);
  localparam int TILE_SHIFT     = 6;  // 64 pixel tiles

  // Player position in pixels
  localparam int POS_X_WIDTH = 11;
  localparam int POS_Y_WIDTH = 10;
  localparam int INIT_X      = 96;  // Centre of row 1, col 1
  localparam int INIT_Y      = 96;
  localparam int STEP_SIZE   = 4;

  // Bomb timing and queueing
  localparam int FUSE_TICKS       = 3;
  localparam int FUSE_WIDTH       = $clog2(FUSE_TICKS + 1);
  localparam int BOMB_QUEUE_DEPTH = 4;

  typedef enum logic [1:0] {
    FLOOR = 2'd0,
    WALL  = 2'd1,
    BRICK = 2'd2,
    BOMB  = 2'd3
  } tile_t;

  // Tile where a bomb goes
  typedef struct packed {
    logic [3:0] row;
    logic [4:0] col;
  } bomb_req_t;

  // Row major tile address
  function automatic logic [MAP_ADDR_WIDTH-1:0] tile_addr(
    input logic [3:0] row,
    input logic [4:0] col
  );
    return MAP_ADDR_WIDTH'(row * MAP_NUM_COL + col);
  endfunction

endpackage

// File: include/bomber_dir.svh
`ifndef BOMBER_DIR_SVH
`define BOMBER_DIR_SVH

// Direction held during one frame
typedef enum logic [2:0] {
  DIR_NONE  = 3'd0,
  DIR_UP    = 3'd1,
  DIR_DOWN  = 3'd2,
  DIR_LEFT  = 3'd3,
  DIR_RIGHT = 3'd4
} dir_t;

`endif
